// ==== src/frv_macros.svh ====
/*
 * Widths, depths and micro-op codes for the queue-fed integer pipeline.
 * FRV_QUEUE_DEPTH and FRV_SCRATCH_WORDS must be powers of two.
 */
`ifndef FRV_MACROS_SVH
`define FRV_MACROS_SVH

`define FRV_XLEN          32     // Data word width
`define FRV_REG_ADDR_W    5      // GPR address width
`define FRV_QUEUE_DEPTH   4      // Queue slots, also producer credits
`define FRV_SCRATCH_WORDS 16     // Scratchpad size in words

// ------------------------------------------------------------------------
// Micro-op codes, ADDI shares ADD
`define FRV_UOP_W         3
`define FRV_UOP_ADD       `FRV_UOP_W'd0
`define FRV_UOP_SUB       `FRV_UOP_W'd1
`define FRV_UOP_XOR       `FRV_UOP_W'd2
`define FRV_UOP_LW        `FRV_UOP_W'd3
`define FRV_UOP_SW        `FRV_UOP_W'd4
`define FRV_UOP_TRAP      `FRV_UOP_W'd5  // Unknown encoding, no writeback

`endif

// ==== src/frv_pkg.sv ====
/*
 * Pipeline types. Stage registers are packed structs, valid is the MSB.
 */
`include "frv_macros.svh"

package frv_pkg;

    typedef logic [`FRV_XLEN-1:0]       xword_t;    // Data word
    typedef logic [`FRV_REG_ADDR_W-1:0] reg_addr_t; // GPR address
    typedef logic [31:0]                instr_t;    // Raw instruction
    typedef logic [`FRV_UOP_W-1:0]      uop_t;      // Micro-op code

    // Decode to execute (s2)
    typedef struct packed {
        logic      valid;
        uop_t      uop;
        reg_addr_t rd;         // Zero when nothing is written
        xword_t    opr_a;      // rs1 value
        xword_t    opr_b;      // Immediate or rs2 value
        xword_t    store_data; // rs2 value for SW
    } dec_op_t;

    // Execute to memory (s3)
    typedef struct packed {
        logic      valid;
        uop_t      uop;
        reg_addr_t rd;
        xword_t    result;     // ALU value or address
        xword_t    store_data;
    } exe_op_t;

    // Forwarding view of one stage
    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        xword_t    wdata;
        logic      load;       // Data not ready yet
    } fwd_t;

    // Writeback (s4)
    typedef struct packed {
        logic      valid;
        logic      trap;
        reg_addr_t rd;
        xword_t    wdata;
    } wb_op_t;

endpackage

// ==== src/frv_instr_queue.sv ====
/*
 * Instruction FIFO under credit flow control. No overflow guard, the
 * producer must hold a credit for each push. One credit per pop.
 */
`timescale 1ns/1ps
`include "frv_macros.svh"

module frv_instr_queue (
    input  logic            g_clk,      // Global clock
    input  logic            rst,        // Synchronous reset
    input  logic            in_valid,   // Push from producer
    input  frv_pkg::instr_t in_instr,   // Pushed instruction
    input  logic            pop,        // Decode takes the head
    output logic            in_credit,  // One cycle per pop
    output logic            head_valid, // Queue not empty
    output frv_pkg::instr_t head_instr  // Oldest entry
);
    import frv_pkg::*;

    localparam int PTR_W = $clog2(`FRV_QUEUE_DEPTH);

    instr_t           slots [`FRV_QUEUE_DEPTH]; // Payload, no reset
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;                    // 0 to depth
    logic             do_pop;

    assign head_valid = (count != '0);
    assign head_instr = slots[rd_ptr];
    assign do_pop     = pop && head_valid;     // Ignore pop when empty
    assign in_credit  = do_pop;                // Same cycle as the pop

    always_ff @(posedge g_clk) begin
        if (in_valid) begin
            slots[wr_ptr] <= in_instr;
        end
    end

    // Pointers wrap naturally, depth is a power of two
    always_ff @(posedge g_clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (in_valid) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)   rd_ptr <= rd_ptr + 1'b1;
            count <= count + {{PTR_W{1'b0}}, in_valid} - {{PTR_W{1'b0}}, do_pop};
        end
    end

endmodule

// ==== src/frv_decode.sv ====
/*
 * Decode stage. Supports ADD, SUB, XOR, ADDI, LW and SW only, anything
 * else becomes a trap with rd zero. Unused source addresses read as x0.
 */
`timescale 1ns/1ps
`include "frv_macros.svh"

module frv_decode (
    input  logic               g_clk,      // Global clock
    input  logic               rst,        // Synchronous reset
    input  logic               head_valid, // Queue head present
    input  frv_pkg::instr_t    head_instr, // Queue head
    output logic               pop,        // Take the head
    output frv_pkg::reg_addr_t rs1_addr,
    output frv_pkg::reg_addr_t rs2_addr,
    input  frv_pkg::xword_t    rs1_fwd,    // Forwarded rs1 value
    input  frv_pkg::xword_t    rs2_fwd,    // Forwarded rs2 value
    input  logic               bubble,     // Load-use hold
    output frv_pkg::dec_op_t   s2_op,      // s2 register
    output frv_pkg::fwd_t      s2_fwd      // s2 hazard view
);
    import frv_pkg::*;

    localparam logic [6:0] OPC_OP    = 7'b0110011; // R-type
    localparam logic [6:0] OPC_OPIMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       is_add, is_sub, is_xor, is_addi, is_lw, is_sw, is_r;
    xword_t     imm_i;
    xword_t     imm_s;
    uop_t       uop;
    dec_op_t    dec_next;

    assign opcode = head_instr[6:0];
    assign funct3 = head_instr[14:12];
    assign funct7 = head_instr[31:25];

    assign is_add  = (opcode == OPC_OP) && (funct3 == 3'b000) && (funct7 == 7'b0000000);
    assign is_sub  = (opcode == OPC_OP) && (funct3 == 3'b000) && (funct7 == 7'b0100000);
    assign is_xor  = (opcode == OPC_OP) && (funct3 == 3'b100) && (funct7 == 7'b0000000);
    assign is_addi = (opcode == OPC_OPIMM) && (funct3 == 3'b000);
    assign is_lw   = (opcode == OPC_LOAD)  && (funct3 == 3'b010);
    assign is_sw   = (opcode == OPC_STORE) && (funct3 == 3'b010);
    assign is_r    = is_add || is_sub || is_xor;

    assign imm_i = {{20{head_instr[31]}}, head_instr[31:20]};
    assign imm_s = {{20{head_instr[31]}}, head_instr[31:25], head_instr[11:7]};

    always_comb begin
        uop = `FRV_UOP_TRAP;                       // Default for unknown
        if (is_add || is_addi) uop = `FRV_UOP_ADD;
        if (is_sub)            uop = `FRV_UOP_SUB;
        if (is_xor)            uop = `FRV_UOP_XOR;
        if (is_lw)             uop = `FRV_UOP_LW;
        if (is_sw)             uop = `FRV_UOP_SW;
    end

    // Keeps immediate bits out of the hazard match
    assign rs1_addr = (is_r || is_addi || is_lw || is_sw) ? head_instr[19:15] : '0;
    assign rs2_addr = (is_r || is_sw) ? head_instr[24:20] : '0;

    assign pop = head_valid && !bubble;        // Bubble holds the head

    assign dec_next.valid      = pop;          // Invalid entry on bubble
    assign dec_next.uop        = uop;
    assign dec_next.rd         = (is_r || is_addi || is_lw) ? head_instr[11:7] : '0;
    assign dec_next.opr_a      = rs1_fwd;
    assign dec_next.opr_b      = is_r ? rs2_fwd : (is_sw ? imm_s : imm_i);
    assign dec_next.store_data = rs2_fwd;

    always_ff @(posedge g_clk) begin
        s2_op <= dec_next;
        if (rst) s2_op.valid <= 1'b0;
    end

    // s2 data comes from the execute ALU, not from here
    assign s2_fwd.valid = s2_op.valid;
    assign s2_fwd.rd    = s2_op.rd;
    assign s2_fwd.wdata = '0;
    assign s2_fwd.load  = (s2_op.uop == `FRV_UOP_LW);

endmodule

// ==== src/frv_hazard.sv ====
/*
 * Operand forwarding and load-use bubble for decode. Youngest stage wins.
 * A load in s2 or s3 has no data yet, so a match there stalls decode.
 */
`timescale 1ns/1ps

module frv_hazard (
    input  frv_pkg::reg_addr_t rs1_addr,  // Decode sources
    input  frv_pkg::reg_addr_t rs2_addr,
    input  frv_pkg::fwd_t      s2_fwd,    // Execute stage view
    input  frv_pkg::xword_t    s2_result, // Live ALU result of s2
    input  frv_pkg::fwd_t      s3_fwd,    // Memory stage view
    input  frv_pkg::fwd_t      s4_fwd,    // Writeback view
    input  frv_pkg::xword_t    rs1_rdata, // Register file values
    input  frv_pkg::xword_t    rs2_rdata,
    output frv_pkg::xword_t    rs1_fwd,
    output frv_pkg::xword_t    rs2_fwd,
    output logic               bubble
);
    import frv_pkg::*;

    logic m1_s2, m1_s3, m1_s4; // rs1 matches
    logic m2_s2, m2_s3, m2_s4; // rs2 matches

    function automatic logic hit(input reg_addr_t addr, input fwd_t f);
        hit = f.valid && (f.rd == addr) && (addr != '0); // x0 never forwards
    endfunction

    assign m1_s2 = hit(rs1_addr, s2_fwd);
    assign m1_s3 = hit(rs1_addr, s3_fwd);
    assign m1_s4 = hit(rs1_addr, s4_fwd);
    assign m2_s2 = hit(rs2_addr, s2_fwd);
    assign m2_s3 = hit(rs2_addr, s3_fwd);
    assign m2_s4 = hit(rs2_addr, s4_fwd);

    // ------------------------------------------------------------------------
    // Priority s2, s3, s4, then the register file
    assign rs1_fwd = m1_s2 ? s2_result    :
                     m1_s3 ? s3_fwd.wdata :
                     m1_s4 ? s4_fwd.wdata :
                             rs1_rdata;

    assign rs2_fwd = m2_s2 ? s2_result    :
                     m2_s3 ? s3_fwd.wdata :
                     m2_s4 ? s4_fwd.wdata :
                             rs2_rdata;

    assign bubble = (s2_fwd.load && (m1_s2 || m2_s2)) ||
                    (s3_fwd.load && (m1_s3 || m2_s3));  // s4 load data is ready

endmodule

// ==== src/frv_gprs.sv ====
/*
 * Register file, 31 writable registers and x0 tied to zero.
 * Two asynchronous read ports, one write port from writeback.
 */
`timescale 1ns/1ps

module frv_gprs (
    input  logic               g_clk,     // Global clock
    input  logic               rst,       // Synchronous reset
    input  frv_pkg::reg_addr_t rs1_addr,
    input  frv_pkg::reg_addr_t rs2_addr,
    output frv_pkg::xword_t    rs1_rdata,
    output frv_pkg::xword_t    rs2_rdata,
    input  frv_pkg::wb_op_t    wb         // Writeback entry
);
    import frv_pkg::*;

    xword_t regs [1:31]; // No storage for x0

    always_ff @(posedge g_clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) regs[i] <= '0;
        end else if (wb.valid && !wb.trap && (wb.rd != '0)) begin
            regs[wb.rd] <= wb.wdata;
        end
    end

    assign rs1_rdata = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_rdata = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// ==== src/frv_execute.sv ====
/*
 * Execute stage. ALU for ADD, SUB and XOR, and the address sum for loads
 * and stores. Traps carry a zero result.
 */
`timescale 1ns/1ps
`include "frv_macros.svh"

module frv_execute (
    input  logic             g_clk,     // Global clock
    input  logic             rst,       // Synchronous reset
    input  frv_pkg::dec_op_t s2_op,     // From decode
    output frv_pkg::xword_t  s2_result, // Also forwarded to decode
    output frv_pkg::exe_op_t s3_op,     // s3 register
    output frv_pkg::fwd_t    s3_fwd     // s3 hazard view
);

    always_comb begin
        case (s2_op.uop)
            `FRV_UOP_SUB:  s2_result = s2_op.opr_a - s2_op.opr_b;
            `FRV_UOP_XOR:  s2_result = s2_op.opr_a ^ s2_op.opr_b;
            `FRV_UOP_TRAP: s2_result = '0;
            default:       s2_result = s2_op.opr_a + s2_op.opr_b; // ADD, LW, SW
        endcase
    end

    always_ff @(posedge g_clk) begin
        s3_op <= '{valid:      s2_op.valid,
                   uop:        s2_op.uop,
                   rd:         s2_op.rd,
                   result:     s2_result,
                   store_data: s2_op.store_data};
        if (rst) s3_op.valid <= 1'b0;
    end

    // Address only for a load, hence the load flag
    assign s3_fwd.valid = s3_op.valid;
    assign s3_fwd.rd    = s3_op.rd;
    assign s3_fwd.wdata = s3_op.result;
    assign s3_fwd.load  = (s3_op.uop == `FRV_UOP_LW);

endmodule

// ==== src/frv_memory.sv ====
/*
 * Memory stage with a small scratchpad, cleared on reset. Word access
 * only, indexed by address bits 5:2 so higher addresses alias.
 */
`timescale 1ns/1ps
`include "frv_macros.svh"

module frv_memory (
    input  logic             g_clk,  // Global clock
    input  logic             rst,    // Synchronous reset
    input  frv_pkg::exe_op_t s3_op,  // From execute
    output frv_pkg::fwd_t    s3_fwd, // s3 view with load data
    output frv_pkg::wb_op_t  wb      // s4 register
);
    import frv_pkg::*;

    localparam int IDX_W = $clog2(`FRV_SCRATCH_WORDS);

    xword_t           scratch [`FRV_SCRATCH_WORDS];
    logic [IDX_W-1:0] idx;
    logic             is_lw;
    logic             is_sw;
    xword_t           s3_wdata;  // Value this stage will write back

    assign idx      = s3_op.result[IDX_W+1:2];   // Word index, wraps
    assign is_lw    = (s3_op.uop == `FRV_UOP_LW);
    assign is_sw    = (s3_op.uop == `FRV_UOP_SW);
    assign s3_wdata = is_lw ? scratch[idx] : s3_op.result;

    // Stores commit in s3
    always_ff @(posedge g_clk) begin
        if (rst) begin
            for (int i = 0; i < `FRV_SCRATCH_WORDS; i++) scratch[i] <= '0;
        end else if (s3_op.valid && is_sw) begin
            scratch[idx] <= s3_op.store_data;
        end
    end

    always_ff @(posedge g_clk) begin
        wb.trap  <= (s3_op.uop == `FRV_UOP_TRAP);
        wb.rd    <= s3_op.rd;
        wb.wdata <= s3_wdata;
        wb.valid <= rst ? 1'b0 : s3_op.valid;
    end

    assign s3_fwd.valid = s3_op.valid;
    assign s3_fwd.rd    = s3_op.rd;
    assign s3_fwd.wdata = s3_wdata;
    assign s3_fwd.load  = is_lw;

endmodule

// ==== src/frv_core.sv ====
/*
 * Top level. Instructions enter through a credit-fed queue and retire on
 * the trace port, one per cycle at most, with no back-pressure.
 */
`timescale 1ns/1ps

module frv_core (
    input  logic               g_clk,     // Global clock
    input  logic               rst,       // Synchronous reset
    input  logic               in_valid,  // Producer push, needs a credit
    input  frv_pkg::instr_t    in_instr,
    output logic               in_credit, // Credit return pulse
    output logic               trs_valid, // Instruction retired
    output logic               trs_trap,  // Retired as a trap
    output frv_pkg::reg_addr_t trs_rd,
    output frv_pkg::xword_t    trs_wdata
);
    import frv_pkg::*;

    logic      head_valid, pop, bubble;
    instr_t    head_instr;
    reg_addr_t rs1_addr, rs2_addr;
    xword_t    rs1_rdata, rs2_rdata, rs1_fwd, rs2_fwd, s2_result;
    dec_op_t   s2_op;
    exe_op_t   s3_op;
    fwd_t      s2_fwd, s3_fwd, s4_fwd;
    wb_op_t    wb;

    // ------------------------------------------------------------------------
    // s4 view, traps never write
    assign s4_fwd = '{valid: wb.valid && !wb.trap, rd: wb.rd,
                      wdata: wb.wdata, load: 1'b0};

    assign trs_valid = wb.valid;
    assign trs_trap  = wb.trap;
    assign trs_rd    = wb.rd;
    assign trs_wdata = wb.wdata;

    frv_instr_queue i_instr_queue (
        .g_clk, .rst, .in_valid, .in_instr, .pop, .in_credit, .head_valid, .head_instr);

    frv_decode i_decode (
        .g_clk, .rst, .head_valid, .head_instr, .pop, .rs1_addr, .rs2_addr,
        .rs1_fwd, .rs2_fwd, .bubble, .s2_op, .s2_fwd);

    frv_hazard i_hazard (
        .rs1_addr, .rs2_addr, .s2_fwd, .s2_result, .s3_fwd, .s4_fwd,
        .rs1_rdata, .rs2_rdata, .rs1_fwd, .rs2_fwd, .bubble);

    frv_gprs i_gprs (.g_clk, .rst, .rs1_addr, .rs2_addr, .rs1_rdata, .rs2_rdata, .wb);

    frv_execute i_execute (.g_clk, .rst, .s2_op, .s2_result, .s3_op, .s3_fwd());

    frv_memory i_memory (.g_clk, .rst, .s3_op, .s3_fwd, .wb);   // s3 view feeds hazard

endmodule

// ==== tests/frv_ref_model.svh ====
/*
 * Reference model of the GPRs and scratchpad, the stimulus LFSR and the
 * instruction encoders. Included inside the testbench module body, after
 * the frv_pkg import. The model is stepped once per issued instruction.
 */
`ifndef FRV_REF_MODEL_SVH
`define FRV_REF_MODEL_SVH

typedef struct packed {
    logic      trap;
    reg_addr_t rd;
    xword_t    wdata;
    logic      check_data;  // Clear for traps
} expect_t;

xword_t      model_regs [32];                     // x0 never written
xword_t      model_scratch [`FRV_SCRATCH_WORDS];
logic [31:0] lfsr_state;

// Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// One step per bit taken
function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_next(lfsr_state);
        v = {v[30:0], lfsr_state[0]};
    end
    return v;
endfunction

function automatic instr_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                 input reg_addr_t rd, input reg_addr_t rs1,
                                 input reg_addr_t rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic instr_t enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                 input reg_addr_t rd, input reg_addr_t rs1,
                                 input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic instr_t enc_addi(input reg_addr_t rd, input reg_addr_t rs1,
                                    input logic [11:0] imm);
    return enc_i(7'b0010011, 3'b000, rd, rs1, imm);
endfunction

function automatic instr_t enc_lw(input reg_addr_t rd, input reg_addr_t rs1,
                                  input logic [11:0] imm);
    return enc_i(7'b0000011, 3'b010, rd, rs1, imm);
endfunction

function automatic instr_t enc_sw(input reg_addr_t rs2, input reg_addr_t rs1,
                                  input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
endfunction

function automatic void model_reset();
    for (int i = 0; i < 32; i++) model_regs[i] = '0;
    for (int i = 0; i < `FRV_SCRATCH_WORDS; i++) model_scratch[i] = '0;
endfunction

// RV32I semantics for the supported subset, traps for the rest
function automatic expect_t apply_model(input instr_t ins);
    expect_t e;
    xword_t  a;
    xword_t  b;
    xword_t  imm_i;
    xword_t  imm_s;
    xword_t  addr;
    logic    is_r;
    a            = model_regs[ins[19:15]];
    b            = model_regs[ins[24:20]];
    imm_i        = {{20{ins[31]}}, ins[31:20]};
    imm_s        = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    is_r         = (ins[6:0] == 7'b0110011);
    e.trap       = 1'b0;
    e.rd         = ins[11:7];
    e.wdata      = '0;
    e.check_data = 1'b1;
    if (is_r && ins[14:12] == 3'b000 && ins[31:25] == 7'h00) begin
        e.wdata = a + b;                             // ADD
    end else if (is_r && ins[14:12] == 3'b000 && ins[31:25] == 7'h20) begin
        e.wdata = a - b;                             // SUB
    end else if (is_r && ins[14:12] == 3'b100 && ins[31:25] == 7'h00) begin
        e.wdata = a ^ b;                             // XOR
    end else if (ins[6:0] == 7'b0010011 && ins[14:12] == 3'b000) begin
        e.wdata = a + imm_i;                         // ADDI
    end else if (ins[6:0] == 7'b0000011 && ins[14:12] == 3'b010) begin
        addr    = a + imm_i;
        e.wdata = model_scratch[addr[5:2]];          // LW, wraps every 64 bytes
    end else if (ins[6:0] == 7'b0100011 && ins[14:12] == 3'b010) begin
        addr                     = a + imm_s;
        model_scratch[addr[5:2]] = b;
        e.rd                     = '0;               // Address shows on the trace
        e.wdata                  = addr;
    end else begin
        e.trap       = 1'b1;
        e.rd         = '0;
        e.check_data = 1'b0;
    end
    if (!e.trap && e.rd != '0) model_regs[e.rd] = e.wdata;
    return e;
endfunction

`endif

// ==== tests/frv_core_tb.sv ====
/*
 * Testbench for frv_core. LFSR-built streams issued under credit flow,
 * retirements checked against the reference model by concurrent
 * assertions. Needs --timing and --assert under Verilator.
 */
`timescale 1ns/1ps
`include "frv_macros.svh"

module frv_core_tb;
    import frv_pkg::*;

    localparam int CLK_PERIOD      = 10;
    localparam int RST_CYCLES      = 16;
    localparam int N_ZERO          = 16;
    localparam int N_ALU           = 200;
    localparam int N_LOAD_USE      = 60;  // 12 groups, gaps of 0 to 2
    localparam int N_WRAP          = 80;
    localparam int N_X0_TRAP       = 40;
    localparam int N_TOTAL         = N_ZERO + N_ALU + N_LOAD_USE + N_WRAP + N_X0_TRAP;
    localparam int WATCHDOG_CYCLES = RST_CYCLES + 40 * N_TOTAL;

    logic      g_clk;
    logic      rst;
    logic      in_valid;
    instr_t    in_instr;
    logic      in_credit;
    logic      trs_valid;
    logic      trs_trap;
    reg_addr_t trs_rd;
    xword_t    trs_wdata;

    `include "frv_ref_model.svh"

    instr_t  stream [$];   // Built, not yet issued
    expect_t exp_q [$];    // Issued, not yet retired
    expect_t exp_cur;      // Retirement under check
    logic    exp_valid;
    logic    rst_phase;    // Reset and idle before the first issue
    int      credits;
    int      issued;
    int      retired;
    int      err_count;
    int      tests_run;
    int      tests_failed;

    frv_core i_frv_core (.g_clk, .rst, .in_valid, .in_instr, .in_credit,
        .trs_valid, .trs_trap, .trs_rd, .trs_wdata);

    always #(CLK_PERIOD / 2) g_clk = ~g_clk;

    task automatic note_error(input string msg);
        err_count++;
        $display("%s", msg);
    endtask

    // ------------------------------------------------------------------------
    // Producer and retirement monitor, both on the falling edge
    always @(negedge g_clk) begin
        in_valid = 1'b0;
        if (!rst && stream.size() != 0 && credits > 0) begin
            if (take_bits(2) != 0) begin          // Idle about one cycle in four
                in_instr  = stream.pop_front();
                in_valid  = 1'b1;
                credits   = credits - 1;
                issued    = issued + 1;
                rst_phase = 1'b0;
                exp_q.push_back(apply_model(in_instr));
            end
        end
        if (in_credit === 1'b1) credits = credits + 1;  // Usable after the coming edge
    end

    always @(negedge g_clk) begin
        if (!rst && trs_valid === 1'b1) begin
            retired   = retired + 1;
            exp_valid = (exp_q.size() != 0);
            if (exp_valid) exp_cur = exp_q.pop_front();
        end
    end

    // ------------------------------------------------------------------------
    // Checks, sampled on the rising edge
    chk_outstanding: assert property (@(posedge g_clk) disable iff (rst)
        trs_valid |-> exp_valid)
        else note_error("A retirement came out with no instruction outstanding");

    chk_trap: assert property (@(posedge g_clk) disable iff (rst)
        trs_valid && exp_valid |-> trs_trap == exp_cur.trap)
        else note_error($sformatf("Fail %0t: trs_trap %0b, expected %0b", $time,
            $sampled(trs_trap), exp_cur.trap));

    chk_rd: assert property (@(posedge g_clk) disable iff (rst)
        trs_valid && exp_valid |-> trs_rd == exp_cur.rd)
        else note_error($sformatf("Fail %0t: trs_rd x%0d, expected x%0d", $time,
            $sampled(trs_rd), exp_cur.rd));

    chk_wdata: assert property (@(posedge g_clk) disable iff (rst)
        trs_valid && exp_valid && exp_cur.check_data |-> trs_wdata == exp_cur.wdata)
        else note_error($sformatf("Fail %0t: trs_wdata %08h, expected %08h", $time,
            $sampled(trs_wdata), exp_cur.wdata));

    chk_credit_range: assert property (@(posedge g_clk)
        credits >= 0 && credits <= `FRV_QUEUE_DEPTH)
        else note_error($sformatf("Fail %0t: producer holds %0d credits", $time,
            $sampled(credits)));

    chk_idle: assert property (@(posedge g_clk) rst_phase |-> !in_credit && !trs_valid)
        else note_error("in_credit or trs_valid rose during reset or before the first issue");

    // ------------------------------------------------------------------------
    // Stream builders, zero time
    task automatic build_scratch_zero();
        for (int i = 0; i < N_ZERO; i++) begin
            stream.push_back(enc_lw(reg_addr_t'(1 + i % 7), 5'd0, 12'(4 * i)));
        end
    endtask

    task automatic build_alu_random();
        logic [1:0] op;
        reg_addr_t  rd;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        for (int i = 1; i < 8; i++) begin                   // Seed x1 to x7
            stream.push_back(enc_addi(reg_addr_t'(i), 5'd0, 12'(take_bits(12))));
        end
        for (int i = 7; i < N_ALU; i++) begin
            op  = 2'(take_bits(2));
            rd  = reg_addr_t'(take_bits(3));                // x0 to x7, dense reuse
            rs1 = reg_addr_t'(take_bits(3));
            rs2 = reg_addr_t'(take_bits(3));
            case (op)
                2'd0:    stream.push_back(enc_r(7'h00, 3'b000, rd, rs1, rs2));
                2'd1:    stream.push_back(enc_r(7'h20, 3'b000, rd, rs1, rs2));
                2'd2:    stream.push_back(enc_r(7'h00, 3'b100, rd, rs1, rs2));
                default: stream.push_back(enc_addi(rd, rs1, 12'(take_bits(12))));
            endcase
        end
    endtask

    task automatic build_load_use();
        logic [11:0] off;
        for (int rep = 0; rep < 4; rep++) begin
            for (int gap = 0; gap < 3; gap++) begin
                off = 12'(take_bits(4) * 4);
                stream.push_back(enc_addi(5'd5, 5'd0, 12'(take_bits(12))));
                stream.push_back(enc_sw(5'd5, 5'd0, off));
                stream.push_back(enc_lw(5'd6, 5'd0, off));
                for (int g = 0; g < gap; g++) begin
                    stream.push_back(enc_addi(5'd7, 5'd7, 12'd1));
                end
                if (rep % 2 == 0) begin
                    stream.push_back(enc_r(7'h00, 3'b000, 5'd1, 5'd6, 5'd0)); // Via rs1
                end else begin
                    stream.push_back(enc_r(7'h00, 3'b100, 5'd1, 5'd0, 5'd6)); // Via rs2
                end
            end
        end
    endtask

    task automatic build_wrap();
        logic [11:0] base;
        for (int k = 0; k < `FRV_SCRATCH_WORDS; k++) begin
            base = 12'(4 * k);
            stream.push_back(enc_addi(5'd2, 5'd0, 12'(take_bits(12))));
            stream.push_back(enc_sw(5'd2, 5'd0, base));
            stream.push_back(enc_addi(5'd3, 5'd0, 12'(take_bits(12))));
            stream.push_back(enc_sw(5'd3, 5'd0, base + 12'(64 * (1 + take_bits(4)))));
            stream.push_back(enc_lw(5'd4, 5'd0, base + 12'(64 * take_bits(4))));
        end
    endtask

    function automatic instr_t illegal_instr(input int sel);
        case (sel)
            0:       return 32'h0000_0000;
            1:       return 32'hffff_ffff;
            2:       return enc_r(7'h01, 3'b000, 5'd1, 5'd1, 5'd2);      // MUL
            3:       return enc_r(7'h00, 3'b001, 5'd1, 5'd1, 5'd2);      // SLL
            4:       return enc_i(7'b0000011, 3'b001, 5'd1, 5'd0, 12'd4); // LH
            5:       return enc_i(7'b0010011, 3'b010, 5'd1, 5'd1, 12'd1); // SLTI
            6:       return enc_r(7'h20, 3'b100, 5'd1, 5'd1, 5'd2);
            default: return {20'h00010, 5'd1, 7'b1101111};               // JAL
        endcase
    endfunction

    task automatic build_x0_trap();
        for (int i = 0; i < 8; i++) begin
            stream.push_back(enc_addi(5'd1, 5'd0, 12'(take_bits(12))));
            stream.push_back(enc_addi(5'd0, 5'd1, 12'(take_bits(12))));  // Traced, not kept
            stream.push_back(enc_r(7'h00, 3'b000, 5'd2, 5'd0, 5'd1));      // x0 reads zero
            stream.push_back(illegal_instr(i));
            stream.push_back(enc_r(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));      // x1, x2 unchanged
        end
    endtask

    // Issue the built stream, wait for the drain, then check the totals
    task automatic run_test(input string name);
        int err0;
        int iss0;
        int ret0;
        err0 = err_count;
        iss0 = issued;
        ret0 = retired;
        while (stream.size() != 0 || exp_q.size() != 0) @(negedge g_clk);
        repeat (3) @(negedge g_clk);                        // Last check settles
        assert (credits == `FRV_QUEUE_DEPTH)
            else note_error($sformatf("Fail %0t: %0d credits after drain, expected %0d",
                $time, credits, `FRV_QUEUE_DEPTH));
        assert (retired - ret0 == issued - iss0)
            else note_error($sformatf("Fail %0t: %0d retired, expected %0d", $time,
                retired - ret0, issued - iss0));
        tests_run++;
        if (err_count != err0) tests_failed++;
        $display("Test %0d %s: %s, issued %0d, retired %0d", tests_run, name,
            (err_count == err0) ? "passed" : "failed", issued - iss0, retired - ret0);
        @(posedge g_clk);
    endtask

    // ------------------------------------------------------------------------
    initial begin
        g_clk        = 1'b0;
        rst          = 1'b1;
        in_valid     = 1'b0;
        in_instr     = '0;
        lfsr_state   = 32'hb40c827b;
        credits      = `FRV_QUEUE_DEPTH;
        issued       = 0;
        retired      = 0;
        err_count    = 0;
        tests_run    = 0;
        tests_failed = 0;
        exp_valid    = 1'b0;
        exp_cur      = '0;
        rst_phase    = 1'b0;
        model_reset();
        @(posedge g_clk);
        @(negedge g_clk);
        rst_phase = 1'b1;                                   // Outputs settled by now
        repeat (RST_CYCLES - 1) @(posedge g_clk);
        @(negedge g_clk);
        rst = 1'b0;
        @(posedge g_clk);
        build_scratch_zero();
        run_test("scratch reads zero after reset");
        build_alu_random();
        run_test("random ALU with forwarding");
        build_load_use();
        run_test("load use with gaps");
        build_wrap();
        run_test("scratchpad wrap");
        build_x0_trap();
        run_test("x0 writes and traps");
        $display("Tests %0d, failed %0d, errors %0d, instructions %0d", tests_run,
            tests_failed, err_count, issued);
        if (err_count == 0 && tests_failed == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // Watchdog, 40 cycles per instruction plus reset
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout after %0d cycles, the pipeline stopped draining", WATCHDOG_CYCLES);
        $display("** FAIL **");
        $finish;
    end

endmodule

// ==== frv_core.f ====
+incdir+src
+incdir+tests
src/frv_pkg.sv
src/frv_instr_queue.sv
src/frv_decode.sv
src/frv_hazard.sv
src/frv_gprs.sv
src/frv_execute.sv
src/frv_memory.sv
src/frv_core.sv
tests/frv_core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build frv_core_tb with Verilator, run it, then look for the pass line in the log
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=frv_core_tb

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        -f frv_core.f --top-module "$TOP" -o frv_core_sim; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/frv_core_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qxF '** PASS **' "$LOG"; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed, pass line not found in $LOG"
exit 1
